/* cfg_ctrl_trace.txt */
# name op(W write, R read) addr wdata wstrb exp_rdata
# exp_rdata is only compared on reads
wr_user       W 30000010 a5a5a5a5 f 00000000
wr_analyzer   W 30001abc 12345678 3 00000000
wr_bridge     W 30002ffc deadbeef c 00000000
wr_serdes     W 30003004 0badf00d 1 00000000
wr_switch     W 30004100 cafe0001 8 00000000
rd_user       R 30000010 00000000 0 00000010
rd_analyzer   R 30001abc 00000000 0 10001abc
rd_bridge     R 30002ffc 00000000 0 20002ffc
rd_serdes     R 30003004 00000000 0 30003004
rd_switch     R 30004100 00000000 0 40004100
rd_sel_reset  R 30005000 00000000 0 00000000
wr_sel        W 30005000 ffffff16 1 00000000
rd_sel        R 30005000 00000000 0 00000016
wr_sel_nostrb W 30005000 00000003 e 00000000
rd_sel_keep   R 30005000 00000000 0 00000016
wr_sel_offset W 30005004 00000007 f 00000000
rd_sel_offset R 30005000 00000000 0 00000016
wr_sel_full   W 30005000 0000001f f 00000000
rd_sel_full   R 30005000 00000000 0 0000001f
wr_unmapped   W 30006000 11111111 f 00000000
rd_unmapped   R 30006000 00000000 0 ffffffff
wr_unmap_top  W 3ffff000 22222222 f 00000000
rd_unmap_top  R 3ffffffc 00000000 0 ffffffff
rd_user_base  R 30000000 00000000 0 00000000

/* project.f */
cfg_pkg.sv
cfg_slave_port.sv
cfg_target_decode.sv
cfg_master_seq.sv
cfg_rsp_select.sv
cfg_prj_sel_reg.sv
cfg_ctrl.sv
tb_cfg_ctrl.sv

/* Makefile */
TOP = tb_cfg_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -o Vtb

run: compile
	./obj_dir/Vtb

clean:
	rm -rf obj_dir

/* tb_cfg_ctrl.sv */
`timescale 1ns/1ps

module tb_cfg_ctrl import cfg_pkg::*; ();

	localparam int unsigned PRJ_SEL_W = 5;
	localparam int          TIMEOUT   = 100; // Cycles allowed per wait

	logic                   axi_clk;
	logic                   axi_reset_n;
	logic                   aa_awvalid;
	logic [31:0]            aa_awaddr;
	logic                   aa_wvalid;
	logic [31:0]            aa_wdata;
	logic [3:0]             aa_wstrb;
	logic                   aa_arvalid;
	logic [31:0]            aa_araddr;
	logic                   aa_rready;
	logic                   aa_awready;
	logic                   aa_wready;
	logic                   aa_arready;
	logic                   aa_rvalid;
	logic [31:0]            aa_rdata;
	mst_bus_t               mst;
	tgt_rsp_t [NUM_TGT-1:0] tgt_rsp;
	logic [NUM_TGT-1:0]     tgt_en;
	logic [PRJ_SEL_W-1:0]   user_prj_sel;

	integer               seed = 54714;
	int                   wait_cnt;
	logic [8*24-1:0]      test_name;
	logic [NUM_TGT-1:0]   exp_en;    // Enable expected while a valid is up
	logic [31:0]          exp_addr;
	logic [31:0]          exp_wdata;
	logic [3:0]           exp_wstrb;
	logic [PRJ_SEL_W-1:0] exp_sel;
	logic                 saw_valid; // Request reached the downstream port

	cfg_ctrl #(.PRJ_SEL_W(PRJ_SEL_W)) u_dut (
		.aa_awvalid_i (aa_awvalid),
		.aa_awaddr_i  (aa_awaddr),
		.aa_wvalid_i  (aa_wvalid),
		.aa_wdata_i   (aa_wdata),
		.aa_wstrb_i   (aa_wstrb),
		.aa_arvalid_i (aa_arvalid),
		.aa_araddr_i  (aa_araddr),
		.aa_rready_i  (aa_rready),
		.aa_awready_o (aa_awready),
		.aa_wready_o  (aa_wready),
		.aa_arready_o (aa_arready),
		.aa_rvalid_o  (aa_rvalid),
		.aa_rdata_o   (aa_rdata),
		.mst_o        (mst),
		.tgt_rsp_i    (tgt_rsp),
		.tgt_en_o     (tgt_en),
		.user_prj_sel_o (user_prj_sel),
		.axi_clk      (axi_clk),
		.axi_reset_n  (axi_reset_n)
	);

	initial begin
		axi_clk = 1'b0;
		forever #20 axi_clk = ~axi_clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	task automatic fail_now(input string what);
		$display("%0s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_equal(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else fail_now($sformatf(
			"ERROR %0s %0s: expected %h actual %h", test_name, field, expected, actual));
	endtask

	task automatic next_cycle();
		@(posedge axi_clk);
		#1; // Drive and sample just after the edge
	endtask

	task automatic wait_step(input string what);
		next_cycle();
		wait_cnt++;
		if (wait_cnt > TIMEOUT) fail_now($sformatf("%0s: no %0s within %0d cycles",
			test_name, what, TIMEOUT));
	endtask

	// One-hot enable from the page map
	function automatic logic [NUM_TGT-1:0] enable_for_addr(input logic [31:0] addr);
		logic [19:0]        page;
		logic [NUM_TGT-1:0] one;
		page = addr[31:12];
		one  = 1;
		if (page >= 20'h30000 && page <= 20'h30004) return one << (page - 20'h30000);
		return '0;
	endfunction

	function automatic int target_index(input logic [NUM_TGT-1:0] en);
		for (int i = 0; i < NUM_TGT; i++) begin
			if (en[i]) return i;
		end
		return 0;
	endfunction

	//////////////////////////////
	// Target models
	//////////////////////////////
	task automatic serve_write(input int idx);
		int aw_dly;
		int w_dly;
		aw_dly = $random(seed) & 3; // Address and data readies come apart or together
		w_dly  = $random(seed) & 3;
		for (int n = 0; n < 4; n++) begin
			tgt_rsp[idx].awready = (n == aw_dly);
			tgt_rsp[idx].wready  = (n == w_dly);
			next_cycle();
		end
		tgt_rsp = '0;
	endtask

	task automatic serve_read(input int idx);
		int                    ar_dly;
		int                    r_dly;
		logic [MST_ADDR_W-1:0] addr;
		addr   = mst.araddr; // Gone once arready is taken
		ar_dly = $random(seed) & 3;
		r_dly  = ar_dly + ($random(seed) & 1);
		for (int n = 0; n < 5; n++) begin
			tgt_rsp[idx].arready = (n == ar_dly);
			tgt_rsp[idx].rvalid  = (n == r_dly);
			tgt_rsp[idx].rdata   = (n == r_dly) ? {4'(idx), 13'd0, addr} : '0;
			next_cycle();
		end
		tgt_rsp = '0;
	endtask

	initial begin
		tgt_rsp = '0;
		forever begin
			next_cycle();
			if (tgt_en != '0 && mst.awvalid) serve_write(target_index(tgt_en));
			else if (tgt_en != '0 && mst.arvalid) serve_read(target_index(tgt_en));
		end
	end

	// Downstream monitor
	initial begin
		forever begin
			next_cycle();
			if (mst.awvalid || mst.arvalid) begin
				saw_valid = 1'b1;
				check_equal("tgt_en", 32'(exp_en), 32'(tgt_en));
			end
			if (mst.awvalid) check_equal("awaddr", 32'(exp_addr[14:0]), 32'(mst.awaddr));
			if (mst.arvalid) begin
				check_equal("araddr", 32'(exp_addr[14:0]), 32'(mst.araddr));
				check_equal("rready", 32'(1), 32'(mst.rready)); // Raised with arvalid
			end
			if (mst.wvalid) begin
				check_equal("wdata", exp_wdata, mst.wdata);
				check_equal("wstrb", 32'(exp_wstrb), 32'(mst.wstrb));
			end
		end
	end

	//////////////////////////////
	// Upstream transactions
	//////////////////////////////
	task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		exp_en     = enable_for_addr(addr);
		exp_addr   = addr;
		exp_wdata  = data;
		exp_wstrb  = strb;
		saw_valid  = 1'b0;
		aa_awvalid = 1'b1;
		aa_awaddr  = addr;
		aa_wvalid  = 1'b1;
		aa_wdata   = data;
		aa_wstrb   = strb;
		wait_cnt   = 0;
		do wait_step("awready"); while (aa_awready !== 1'b1);
		aa_awvalid = 1'b0;
		wait_cnt   = 0;
		do wait_step("wready"); while (aa_wready !== 1'b1);
		aa_wvalid = 1'b0;
		if (addr[31:12] == 20'h30005 && addr[11:0] == 12'h000 && strb[0]) begin
			exp_sel = data[PRJ_SEL_W-1:0]; // Select takes the low data bits
		end
		check_equal("user_prj_sel", 32'(exp_sel), 32'(user_prj_sel));
		assert (saw_valid) else fail_now($sformatf("%0s: write never left the controller",
			test_name));
	endtask

	task automatic do_read(input logic [31:0] addr, input logic [31:0] expected);
		exp_en     = enable_for_addr(addr);
		exp_addr   = addr;
		saw_valid  = 1'b0;
		aa_arvalid = 1'b1;
		aa_araddr  = addr;
		wait_cnt   = 0;
		do wait_step("arready"); while (aa_arready !== 1'b1);
		aa_arvalid = 1'b0;
		repeat ($random(seed) & 7) next_cycle(); // rready low for a while
		aa_rready = 1'b1;
		wait_cnt  = 0;
		do wait_step("rvalid"); while (aa_rvalid !== 1'b1);
		check_equal("rdata", expected, aa_rdata);
		aa_rready = 1'b0;
		repeat (2) begin
			next_cycle();
			check_equal("rvalid held", 32'(1), 32'(aa_rvalid));
		end
		aa_rready = 1'b1;
		next_cycle();
		check_equal("rvalid after rready", 32'(0), 32'(aa_rvalid));
		aa_rready = 1'b0;
		assert (saw_valid) else fail_now($sformatf("%0s: read never left the controller",
			test_name));
	endtask

	initial begin
		int          fd;
		int          n_trans;
		int          n_fields;
		string       line;
		logic [7:0]  op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic [31:0] rdata_exp;
		{aa_awvalid, aa_awaddr, aa_wvalid, aa_wdata, aa_wstrb} = '0;
		{aa_arvalid, aa_araddr, aa_rready} = '0;
		{exp_en, exp_addr, exp_wdata, exp_wstrb, exp_sel, saw_valid} = '0;
		test_name   = "reset";
		axi_reset_n = 1'b0;
		repeat (8) @(posedge axi_clk);
		#1;
		axi_reset_n = 1'b1;
		next_cycle();
		check_equal("readies", 32'(0), 32'({aa_awready, aa_wready, aa_arready}));
		check_equal("rvalid", 32'(0), 32'(aa_rvalid));
		check_equal("tgt_en", 32'(0), 32'(tgt_en));
		check_equal("user_prj_sel", 32'(0), 32'(user_prj_sel));

		fd = $fopen("cfg_ctrl_trace.txt", "r");
		assert (fd != 0) else fail_now("cannot open cfg_ctrl_trace.txt");
		n_trans = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#") begin
				n_fields = $sscanf(line, "%s %s %h %h %h %h", test_name, op, addr, wdata,
					wstrb, rdata_exp);
				assert (n_fields == 6) else fail_now({"malformed trace line: ", line});
				if (op == "W") do_write(addr, wdata, wstrb);
				else do_read(addr, rdata_exp);
				n_trans++;
				repeat (2) next_cycle();
			end
		end
		$fclose(fd);
		if (n_trans == 0) begin
			fail_now("trace file held no transactions");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

/* cfg_ctrl.sv */
`timescale 1ns/1ps

module cfg_ctrl import cfg_pkg::*; #(
	parameter int unsigned PRJ_SEL_W = 5
) (
	input  logic                   aa_awvalid_i,
	input  logic [31:0]            aa_awaddr_i,
	input  logic                   aa_wvalid_i,
	input  logic [31:0]            aa_wdata_i,
	input  logic [3:0]             aa_wstrb_i,
	input  logic                   aa_arvalid_i,
	input  logic [31:0]            aa_araddr_i,
	input  logic                   aa_rready_i,
	output logic                   aa_awready_o,
	output logic                   aa_wready_o,
	output logic                   aa_arready_o,
	output logic                   aa_rvalid_o,
	output logic [31:0]            aa_rdata_o,
	output mst_bus_t               mst_o,
	input  tgt_rsp_t [NUM_TGT-1:0] tgt_rsp_i,
	output logic [NUM_TGT-1:0]     tgt_en_o,
	output logic [PRJ_SEL_W-1:0]   user_prj_sel_o,
	input  logic                   axi_clk,
	input  logic                   axi_reset_n
);

	cfg_req_t    req;
	logic        req_done;
	logic [31:0] rd_data;
	tgt_sel_t    sel;
	tgt_rsp_t    local_rsp;
	tgt_rsp_t    seq_rsp; // Merged response seen by the sequencer

	assign tgt_en_o = sel.ext_en;

	//////////////////////////////
	// Front end
	//////////////////////////////
	cfg_slave_port u_slave_port (
		.axi_clk      (axi_clk),
		.axi_reset_n  (axi_reset_n),
		.aa_awvalid_i (aa_awvalid_i),
		.aa_awaddr_i  (aa_awaddr_i),
		.aa_wvalid_i  (aa_wvalid_i),
		.aa_wdata_i   (aa_wdata_i),
		.aa_wstrb_i   (aa_wstrb_i),
		.aa_arvalid_i (aa_arvalid_i),
		.aa_araddr_i  (aa_araddr_i),
		.aa_rready_i  (aa_rready_i),
		.aa_awready_o (aa_awready_o),
		.aa_wready_o  (aa_wready_o),
		.aa_arready_o (aa_arready_o),
		.aa_rvalid_o  (aa_rvalid_o),
		.aa_rdata_o   (aa_rdata_o),
		.req_o        (req),
		.req_done_i   (req_done),
		.rd_data_i    (rd_data)
	);

	cfg_target_decode u_target_decode (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.req_addr_i  (req.addr),
		.sel_o       (sel)
	);

	cfg_master_seq u_master_seq (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.req_i       (req),
		.rsp_i       (seq_rsp),
		.mst_o       (mst_o),
		.req_done_o  (req_done),
		.rd_data_o   (rd_data)
	);

	//////////////////////////////
	// Response path
	//////////////////////////////
	cfg_rsp_select #(
		.PRJ_SEL_W (PRJ_SEL_W)
	) u_rsp_select (
		.sel_i       (sel),
		.tgt_rsp_i   (tgt_rsp_i),
		.local_rsp_i (local_rsp),
		.mst_i       (mst_o),
		.rsp_o       (seq_rsp)
	);

	cfg_prj_sel_reg #(
		.PRJ_SEL_W (PRJ_SEL_W)
	) u_prj_sel_reg (
		.axi_clk        (axi_clk),
		.axi_reset_n    (axi_reset_n),
		.local_en_i     (sel.local_en),
		.mst_i          (mst_o),
		.rsp_o          (local_rsp),
		.user_prj_sel_o (user_prj_sel_o)
	);

endmodule

/* cfg_prj_sel_reg.sv */
`timescale 1ns/1ps

module cfg_prj_sel_reg import cfg_pkg::*; #(
	parameter int unsigned PRJ_SEL_W = 5
) (
	input  logic                 axi_clk,
	input  logic                 axi_reset_n,
	input  logic                 local_en_i,
	input  mst_bus_t             mst_i,
	output tgt_rsp_t             rsp_o,
	output logic [PRJ_SEL_W-1:0] user_prj_sel_o
);

	logic sel_wr; // Write to offset 0 with byte 0 enabled

	assign sel_wr = local_en_i && mst_i.awvalid && mst_i.wvalid &&
		(mst_i.awaddr[PAGE_LSB-1:0] == '0) && mst_i.wstrb[0];

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			user_prj_sel_o <= '0;
		end else if (sel_wr) begin
			user_prj_sel_o <= mst_i.wdata[PRJ_SEL_W-1:0];
		end
	end

	// Zero wait state slave
	assign rsp_o.awready = mst_i.awvalid;
	assign rsp_o.wready  = mst_i.wvalid;
	assign rsp_o.arready = mst_i.arvalid;
	assign rsp_o.rvalid  = mst_i.arvalid;
	assign rsp_o.rdata   = 32'(user_prj_sel_o); // Zero-extended

endmodule

/* cfg_rsp_select.sv */
`timescale 1ns/1ps

module cfg_rsp_select import cfg_pkg::*; #(
	parameter int unsigned PRJ_SEL_W = 5
) (
	input  tgt_sel_t               sel_i,
	input  tgt_rsp_t [NUM_TGT-1:0] tgt_rsp_i,
	input  tgt_rsp_t               local_rsp_i,
	input  mst_bus_t               mst_i,
	output tgt_rsp_t               rsp_o
);

	localparam int unsigned RSP_W = $bits(tgt_rsp_t);
	// Only the select bits of the local read word are meaningful
	localparam logic [31:0] LOCAL_MASK = 32'((64'd1 << PRJ_SEL_W) - 64'd1);

	tgt_rsp_t         local_rsp;
	tgt_rsp_t         unmap_rsp;
	logic [RSP_W-1:0] merged;

	always_comb begin
		local_rsp       = local_rsp_i;
		local_rsp.rdata = local_rsp_i.rdata & LOCAL_MASK;

		// Unmapped range accepts everything and reads back all ones
		unmap_rsp.awready = mst_i.awvalid;
		unmap_rsp.wready  = mst_i.wvalid;
		unmap_rsp.arready = mst_i.arvalid;
		unmap_rsp.rvalid  = mst_i.arvalid;
		unmap_rsp.rdata   = '1;

		merged = {RSP_W{sel_i.local_en}} & local_rsp;
		merged = merged | ({RSP_W{sel_i.unmapped}} & unmap_rsp);
		for (int i = 0; i < NUM_TGT; i++) begin
			merged = merged | ({RSP_W{sel_i.ext_en[i]}} & tgt_rsp_i[i]);
		end
	end

	assign rsp_o = tgt_rsp_t'(merged);

endmodule

/* cfg_master_seq.sv */
`timescale 1ns/1ps

module cfg_master_seq import cfg_pkg::*; (
	input  logic        axi_clk,
	input  logic        axi_reset_n,
	input  cfg_req_t    req_i,
	input  tgt_rsp_t    rsp_i,
	output mst_bus_t    mst_o,
	output logic        req_done_o,
	output logic [31:0] rd_data_o
);

	typedef enum logic [1:0] {
		SQ_IDLE,
		SQ_WRITE,
		SQ_READ
	} seq_state_e;

	seq_state_e state_q;
	mst_bus_t   mst_q;
	logic       aw_ok; // Address phase finished now or earlier
	logic       w_ok;  // Data phase finished now or earlier

	assign mst_o = mst_q;
	assign aw_ok = !mst_q.awvalid || rsp_i.awready;
	assign w_ok  = !mst_q.wvalid || rsp_i.wready;

	//////////////////////////////
	// Downstream FSM
	//////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state_q    <= SQ_IDLE;
			mst_q      <= '0;
			req_done_o <= 1'b0;
		end else begin
			req_done_o <= 1'b0;

			case (state_q)
				SQ_IDLE: begin
					// Done still high means the slave port has not cleared pending yet
					if (req_i.pending && !req_done_o) begin
						if (req_i.write) begin
							mst_q.awvalid <= 1'b1;
							mst_q.awaddr  <= req_i.addr[MST_ADDR_W-1:0];
							mst_q.wvalid  <= 1'b1;
							mst_q.wdata   <= req_i.data;
							mst_q.wstrb   <= req_i.strb;
							state_q       <= SQ_WRITE;
						end else begin
							mst_q.arvalid <= 1'b1;
							mst_q.araddr  <= req_i.addr[MST_ADDR_W-1:0];
							mst_q.rready  <= 1'b1;
							state_q       <= SQ_READ;
						end
					end
				end
				SQ_WRITE: begin
					if (rsp_i.awready) begin
						mst_q.awvalid <= 1'b0;
						mst_q.awaddr  <= '0;
					end
					if (rsp_i.wready) begin
						mst_q.wvalid <= 1'b0;
						mst_q.wdata  <= '0;
						mst_q.wstrb  <= '0;
					end
					if (aw_ok && w_ok) begin // Readies may come together or apart
						req_done_o <= 1'b1;
						state_q    <= SQ_IDLE;
					end
				end
				SQ_READ: begin
					if (rsp_i.arready || rsp_i.rvalid) begin
						mst_q.arvalid <= 1'b0;
						mst_q.araddr  <= '0;
					end
					if (rsp_i.rvalid) begin
						mst_q.rready <= 1'b0;
						req_done_o   <= 1'b1;
						state_q      <= SQ_IDLE;
					end
				end
				default: state_q <= SQ_IDLE;
			endcase
		end
	end

	// Read data capture
	always_ff @(posedge axi_clk) begin
		if (state_q == SQ_READ && rsp_i.rvalid) begin
			rd_data_o <= rsp_i.rdata;
		end
	end

endmodule

/* cfg_target_decode.sv */
`timescale 1ns/1ps

module cfg_target_decode import cfg_pkg::*; (
	input  logic        axi_clk,
	input  logic        axi_reset_n,
	input  logic [31:0] req_addr_i,
	output tgt_sel_t    sel_o
);

	localparam int unsigned PAGE_W = 32 - PAGE_LSB;

	logic [PAGE_W-1:0] page;
	logic [31:0]       page_ext; // Page widened for compares against the map words
	tgt_sel_t          sel_d;

	assign page     = req_addr_i[31:PAGE_LSB];
	assign page_ext = 32'(page);

	//////////////////////////////
	// Page compares
	//////////////////////////////
	always_comb begin
		sel_d = '0;
		sel_d.ext_en[TGT_USER]     = (page_ext == TGT_PAGE_BASE + TGT_USER);
		sel_d.ext_en[TGT_ANALYZER] = (page_ext == TGT_PAGE_BASE + TGT_ANALYZER);
		sel_d.ext_en[TGT_BRIDGE]   = (page_ext == TGT_PAGE_BASE + TGT_BRIDGE);
		sel_d.ext_en[TGT_SERDES]   = (page_ext == TGT_PAGE_BASE + TGT_SERDES);
		sel_d.ext_en[TGT_SWITCH]   = (page_ext == TGT_PAGE_BASE + TGT_SWITCH);
		sel_d.local_en = (page_ext == LOCAL_PAGE);
		// Everything above the local page up to the end of the window
		sel_d.unmapped = (page_ext > LOCAL_PAGE) && (page_ext <= UNMAPPED_PAGE_LAST);
	end

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			sel_o <= '0;
		end else begin
			sel_o <= sel_d; // One cycle behind the address
		end
	end

endmodule

/* cfg_slave_port.sv */
`timescale 1ns/1ps

module cfg_slave_port import cfg_pkg::*; (
	input  logic        axi_clk,
	input  logic        axi_reset_n,
	input  logic        aa_awvalid_i,
	input  logic [31:0] aa_awaddr_i,
	input  logic        aa_wvalid_i,
	input  logic [31:0] aa_wdata_i,
	input  logic [3:0]  aa_wstrb_i,
	input  logic        aa_arvalid_i,
	input  logic [31:0] aa_araddr_i,
	input  logic        aa_rready_i,
	output logic        aa_awready_o,
	output logic        aa_wready_o,
	output logic        aa_arready_o,
	output logic        aa_rvalid_o,
	output logic [31:0] aa_rdata_o,
	output cfg_req_t    req_o,
	input  logic        req_done_i,
	input  logic [31:0] rd_data_i
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RD_WAIT,
		ST_RD_HOLD,
		ST_WR_DATA,
		ST_WR_WAIT
	} slv_state_e;

	slv_state_e state_q;
	cfg_req_t   req_q;
	logic       rd_done_q; // Read data in hand while rready is still low

	assign req_o = req_q;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state_q      <= ST_IDLE;
			req_q        <= '0;
			rd_done_q    <= 1'b0;
			aa_awready_o <= 1'b0;
			aa_wready_o  <= 1'b0;
			aa_arready_o <= 1'b0;
			aa_rvalid_o  <= 1'b0;
			aa_rdata_o   <= '0;
		end else begin
			// Handshake pulses last one cycle
			aa_awready_o <= 1'b0;
			aa_wready_o  <= 1'b0;
			aa_arready_o <= 1'b0;

			case (state_q)
				ST_IDLE: begin
					if (aa_awvalid_i) begin // Write wins over read
						aa_awready_o <= 1'b1;
						req_q.addr   <= aa_awaddr_i;
						req_q.write  <= 1'b1;
						state_q      <= ST_WR_DATA;
					end else if (aa_arvalid_i) begin
						aa_arready_o  <= 1'b1;
						req_q.addr    <= aa_araddr_i;
						req_q.write   <= 1'b0;
						req_q.pending <= 1'b1;
						state_q       <= ST_RD_WAIT;
					end
				end
				ST_RD_WAIT: begin
					if (req_done_i) begin
						aa_rdata_o    <= rd_data_i;
						req_q.pending <= 1'b0;
						req_q.addr    <= '0; // Decoder drops back to no target
					end
					if ((req_done_i || rd_done_q) && aa_rready_i) begin
						aa_rvalid_o <= 1'b1;
						rd_done_q   <= 1'b0;
						state_q     <= ST_RD_HOLD;
					end else if (req_done_i) begin
						rd_done_q <= 1'b1;
					end
				end
				ST_RD_HOLD: begin
					if (aa_rready_i) begin
						aa_rvalid_o <= 1'b0;
						aa_rdata_o  <= '0;
						state_q     <= ST_IDLE;
					end
				end
				ST_WR_DATA: begin
					if (aa_wvalid_i) begin
						req_q.data    <= aa_wdata_i;
						req_q.strb    <= aa_wstrb_i;
						req_q.pending <= 1'b1;
						state_q       <= ST_WR_WAIT;
					end
				end
				ST_WR_WAIT: begin
					if (req_done_i) begin
						aa_wready_o   <= 1'b1;
						req_q.pending <= 1'b0;
						req_q.addr    <= '0;
						state_q       <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

/* cfg_pkg.sv */
package cfg_pkg;

	//////////////////////////////
	// Address map
	//////////////////////////////
	localparam int unsigned PAGE_LSB           = 12;            // Page field is addr[31:12]
	localparam logic [31:0] TGT_PAGE_BASE      = 32'h0003_0000; // Page of target 0
	localparam logic [31:0] LOCAL_PAGE         = 32'h0003_0005; // Own register page
	localparam logic [31:0] UNMAPPED_PAGE_LAST = 32'h0003_FFFF;

	localparam int unsigned MST_ADDR_W = 15; // Downstream address width
	localparam int unsigned NUM_TGT    = 5;

	// External target positions at page TGT_PAGE_BASE + index
	typedef enum logic [2:0] {
		TGT_USER     = 3'd0,
		TGT_ANALYZER = 3'd1,
		TGT_BRIDGE   = 3'd2,
		TGT_SERDES   = 3'd3,
		TGT_SWITCH   = 3'd4
	} tgt_idx_e;

	//////////////////////////////
	// Bus bundles
	//////////////////////////////
	typedef struct packed {
		logic        pending; // Request waiting for the downstream side
		logic        write;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
	} cfg_req_t;

	typedef struct packed {
		logic                  awvalid;
		logic [MST_ADDR_W-1:0] awaddr;
		logic                  wvalid;
		logic [31:0]           wdata;
		logic [3:0]            wstrb;
		logic                  arvalid;
		logic [MST_ADDR_W-1:0] araddr;
		logic                  rready;
	} mst_bus_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        arready;
		logic [31:0] rdata;
		logic        rvalid;
	} tgt_rsp_t;

	typedef struct packed {
		logic [NUM_TGT-1:0] ext_en; // One-hot external target enable
		logic               local_en;
		logic               unmapped;
	} tgt_sel_t;

endpackage
